/* include/rob_params.svh */
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// Reorder buffer geometry
`define ROB_DEPTH     16
`define ROB_TAG_BITS  4     // log2 of ROB_DEPTH

// Lanes per cycle at dispatch, completion and commit
`define SS_WIDTH      2

// Wide enough to count from 0 up to SS_WIDTH
`define SS_COUNT_BITS 2

// Result values carried through the buffer
`define DATA_WIDTH    32

// Architectural register file
`define ARCH_REGS     16
`define REG_BITS      4     // log2 of ARCH_REGS

`endif

/* source/uop_pkg.sv */
package uop_pkg;

`include "rob_params.svh"

// Only ALU and LOAD produce a register result
typedef enum logic [1:0] {
    ALU   = 2'd0,
    LOAD  = 2'd1,
    STORE = 2'd2,
    NOP   = 2'd3
} opcode_e;

// Architectural register number
typedef logic [`REG_BITS-1:0] reg_idx_t;

// One micro-op as it arrives from decode
typedef struct packed {
    opcode_e  op;
    reg_idx_t dest;     // Ignored for STORE and NOP
} uop_t;

// True when the opcode writes its destination register
function automatic logic writes_reg(opcode_e op);
    return (op == ALU) || (op == LOAD);
endfunction

endpackage : uop_pkg

/* source/rob_pkg.sv */
package rob_pkg;

`include "rob_params.svh"

import uop_pkg::*;

// Index of a queue slot, handed out as the instruction tag
typedef logic [`ROB_TAG_BITS-1:0] rob_tag_t;

// One bit wider than a tag so it can hold a full count of ROB_DEPTH
typedef logic [`ROB_TAG_BITS:0] rob_count_t;

// One queue slot
typedef struct packed {
    logic                   done;   // Result present or none needed
    opcode_e                op;
    reg_idx_t               dest;
    logic [`DATA_WIDTH-1:0] value;
} rob_entry_t;

// Result reported by an execution unit
typedef struct packed {
    logic                   valid;
    rob_tag_t               tag;
    logic [`DATA_WIDTH-1:0] value;
} complete_t;

// Record of one retired instruction
typedef struct packed {
    logic                   valid;
    opcode_e                op;
    reg_idx_t               dest;
    logic                   wr_reg;   // Set when the register file was updated
    logic [`DATA_WIDTH-1:0] value;
} commit_t;

endpackage : rob_pkg

/* source/dispatch_stage.sv */
`timescale 1ns/1ps

`include "rob_params.svh"

module dispatch_stage import uop_pkg::*, rob_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dispatch,
    input  logic [`SS_COUNT_BITS-1:0]  count,
    input  uop_t [`SS_WIDTH-1:0]       uops,
    input  rob_count_t                 live_count,
    input  rob_tag_t                   tail_tag,
    output logic                       push,
    output logic [`SS_COUNT_BITS-1:0]  push_count,
    output rob_entry_t [`SS_WIDTH-1:0] push_entries,
    output rob_tag_t [`SS_WIDTH-1:0]   alloc_tags,
    output rob_count_t                 space,
    output logic                       overflow
);

rob_count_t pending;    // Slots claimed by the registered dispatch but not yet in the queue
logic       fits;
logic       lane_ok;
logic       accept;

assign pending = push ? rob_count_t'(push_count) : '0;
assign space   = rob_count_t'(`ROB_DEPTH) - live_count - pending;
assign fits    = rob_count_t'(count) <= space;

// A count above the lane width cannot be honoured by the queue
assign lane_ok = count <= `SS_COUNT_BITS'(`SS_WIDTH);
assign accept  = dispatch && fits && lane_ok && (count != '0);

always_ff @(posedge clk) begin
    if (rst) begin
        push       <= 1'b0;
        push_count <= '0;
        overflow   <= 1'b0;
    end else begin
        push       <= accept;
        push_count <= accept ? count : '0;

        // Sticky until the next reset
        if (dispatch && !fits)
            overflow <= 1'b1;
    end
end

// Build the slot contents of an accepted dispatch
always_ff @(posedge clk) begin
    if (accept) begin
        for (int i = 0; i < `SS_WIDTH; i++) begin
            push_entries[i].done  <= !writes_reg(uops[i].op);  // Nothing to wait for
            push_entries[i].op    <= uops[i].op;
            push_entries[i].dest  <= uops[i].dest;
            push_entries[i].value <= '0;
        end
    end
end

// Lane i lands i slots past the current tail
always_comb begin
    for (int i = 0; i < `SS_WIDTH; i++) begin
        alloc_tags[i] = tail_tag + rob_tag_t'(i);
    end
end

endmodule : dispatch_stage

/* source/circular_queue.sv */
`timescale 1ns/1ps

`include "rob_params.svh"

module circular_queue import rob_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  logic [`SS_COUNT_BITS-1:0]  push_count,
    input  rob_entry_t [`SS_WIDTH-1:0] push_entries,
    input  complete_t [`SS_WIDTH-1:0]  completes,
    input  logic                       pop,
    input  logic [`SS_COUNT_BITS-1:0]  pop_count,
    output rob_entry_t [`SS_WIDTH-1:0] oldest,
    output rob_count_t                 live_count,
    output rob_tag_t                   tail_tag
);

rob_entry_t entries [`ROB_DEPTH];

// The extra top bit tells a full queue from an empty one
logic [`ROB_TAG_BITS:0] head;
logic [`ROB_TAG_BITS:0] tail;

rob_tag_t                 head_tag;
rob_tag_t [`SS_WIDTH-1:0] comp_offset;   // Distance of each completion from the head
logic     [`SS_WIDTH-1:0] comp_live;

assign head_tag   = head[`ROB_TAG_BITS-1:0];
assign tail_tag   = tail[`ROB_TAG_BITS-1:0];
assign live_count = tail - head;     // Wraps correctly thanks to the extra bit

// Pointers move by whole lane counts
always_ff @(posedge clk) begin
    if (rst) begin
        head <= '0;
        tail <= '0;
    end else begin
        if (push)
            tail <= tail + rob_count_t'(push_count);
        if (pop)
            head <= head + rob_count_t'(pop_count);
    end
end

// A slot is live when it sits fewer than live_count places past the head
always_comb begin
    for (int i = 0; i < `SS_WIDTH; i++) begin
        comp_offset[i] = completes[i].tag - head_tag;
        comp_live[i]   = rob_count_t'(comp_offset[i]) < live_count;
    end
end

// Slot storage with the in-order push path and the random-access result path
always_ff @(posedge clk) begin
    if (push) begin
        for (int i = 0; i < `SS_WIDTH; i++) begin
            if (i < int'(push_count))
                entries[tail_tag + rob_tag_t'(i)] <= push_entries[i];
        end
    end

    // Pushed slots are not live yet, so the two loops never hit the same entry
    for (int i = 0; i < `SS_WIDTH; i++) begin
        if (completes[i].valid && comp_live[i]) begin
            entries[completes[i].tag].done  <= 1'b1;
            entries[completes[i].tag].value <= completes[i].value;
        end
    end
end

// Head-side window for commit
always_comb begin
    for (int i = 0; i < `SS_WIDTH; i++) begin
        oldest[i] = entries[head_tag + rob_tag_t'(i)];

        // Stale slots past the live region must never look finished
        if (rob_count_t'(i) >= live_count)
            oldest[i].done = 1'b0;
    end
end

endmodule : circular_queue

/* source/commit_stage.sv */
`timescale 1ns/1ps

`include "rob_params.svh"

module commit_stage import uop_pkg::*, rob_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  rob_entry_t [`SS_WIDTH-1:0] oldest,
    input  reg_idx_t                   reg_raddr,
    output logic                       pop,
    output logic [`SS_COUNT_BITS-1:0]  pop_count,
    output commit_t [`SS_WIDTH-1:0]    commits,
    output logic [`DATA_WIDTH-1:0]     reg_rdata
);

logic [`DATA_WIDTH-1:0] regs [`ARCH_REGS];

logic [`SS_WIDTH-1:0] retire;    // Lanes leaving the queue at the next edge
logic [`SS_WIDTH-1:0] reg_we;    // Retiring lanes that carry a register result

// A lane retires only when every older lane retires with it
always_comb begin
    retire[0] = oldest[0].done;
    for (int i = 1; i < `SS_WIDTH; i++) begin
        retire[i] = retire[i-1] && oldest[i].done;
    end
end

always_comb begin
    for (int i = 0; i < `SS_WIDTH; i++) begin
        reg_we[i] = retire[i] && writes_reg(oldest[i].op);
    end
end

// The run is a prefix, so its length is one past the last retiring lane
always_comb begin
    pop_count = '0;
    for (int i = 0; i < `SS_WIDTH; i++) begin
        if (retire[i])
            pop_count = `SS_COUNT_BITS'(i + 1);
    end
end

assign pop = retire[0];

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < `SS_WIDTH; i++) begin
            commits[i] <= '0;
        end
    end else begin
        for (int i = 0; i < `SS_WIDTH; i++) begin
            commits[i].valid  <= retire[i];
            commits[i].op     <= oldest[i].op;
            commits[i].dest   <= oldest[i].dest;
            commits[i].wr_reg <= reg_we[i];
            commits[i].value  <= oldest[i].value;
        end
    end
end

// Architectural state that starts from all zeros
always_ff @(posedge clk) begin
    if (rst) begin
        for (int r = 0; r < `ARCH_REGS; r++) begin
            regs[r] <= '0;
        end
    end else begin
        // Lane 1 is written last and so wins when both lanes share a register
        for (int i = 0; i < `SS_WIDTH; i++) begin
            if (reg_we[i])
                regs[oldest[i].dest] <= oldest[i].value;
        end
    end
end

assign reg_rdata = regs[reg_raddr];

endmodule : commit_stage

/* source/rob_top.sv */
`timescale 1ns/1ps

`include "rob_params.svh"

module rob_top import uop_pkg::*, rob_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,

    // Dispatch side
    input  logic                       dispatch,
    input  logic [`SS_COUNT_BITS-1:0]  count,
    input  uop_t [`SS_WIDTH-1:0]       uops,
    output logic                       alloc,
    output logic [`SS_COUNT_BITS-1:0]  alloc_count,
    output rob_tag_t [`SS_WIDTH-1:0]   alloc_tags,
    output rob_count_t                 space,
    output logic                       overflow,

    // Execution units report here
    input  complete_t [`SS_WIDTH-1:0]  completes,

    // Retirement side
    output commit_t [`SS_WIDTH-1:0]    commits,
    input  reg_idx_t                   reg_raddr,
    output logic [`DATA_WIDTH-1:0]     reg_rdata
);

rob_entry_t [`SS_WIDTH-1:0] push_entries;
rob_entry_t [`SS_WIDTH-1:0] oldest;
rob_count_t                 live_count;
rob_tag_t                   tail_tag;
logic                       pop;
logic [`SS_COUNT_BITS-1:0]  pop_count;

dispatch_stage dispatch0 (
    .clk          (clk),
    .rst          (rst),
    .dispatch     (dispatch),
    .count        (count),
    .uops         (uops),
    .live_count   (live_count),
    .tail_tag     (tail_tag),
    .push         (alloc),          // The push strobe is the alloc strobe seen by the core
    .push_count   (alloc_count),
    .push_entries (push_entries),
    .alloc_tags   (alloc_tags),
    .space        (space),
    .overflow     (overflow)
);

circular_queue queue0 (
    .clk          (clk),
    .rst          (rst),
    .push         (alloc),
    .push_count   (alloc_count),
    .push_entries (push_entries),
    .completes    (completes),
    .pop          (pop),
    .pop_count    (pop_count),
    .oldest       (oldest),
    .live_count   (live_count),
    .tail_tag     (tail_tag)
);

commit_stage commit0 (
    .clk          (clk),
    .rst          (rst),
    .oldest       (oldest),
    .reg_raddr    (reg_raddr),
    .pop          (pop),
    .pop_count    (pop_count),
    .commits      (commits),
    .reg_rdata    (reg_rdata)
);

endmodule : rob_top

/* testbench/rob_tb.sv */
`timescale 1ns/1ps

`include "rob_params.svh"

module rob_tb import uop_pkg::*, rob_pkg::*; ();

localparam int CLK_PERIOD = 40;
localparam int N_RANDOM   = 120;            // Dispatches in each long random run
localparam int N_TRANS    = N_RANDOM + 13;  // Plus the fill, overflow and short runs
localparam int MAX_SEQ    = 512;

logic                       clk;
logic                       rst;
logic                       dispatch;
logic [`SS_COUNT_BITS-1:0]  count;
uop_t [`SS_WIDTH-1:0]       uops;
logic                       alloc;
logic [`SS_COUNT_BITS-1:0]  alloc_count;
rob_tag_t [`SS_WIDTH-1:0]   alloc_tags;
rob_count_t                 space;
logic                       overflow;
complete_t [`SS_WIDTH-1:0]  completes;
commit_t [`SS_WIDTH-1:0]    commits;
reg_idx_t                   reg_raddr;
logic [`DATA_WIDTH-1:0]     reg_rdata;

// Model of every accepted micro-op, indexed by dispatch order
opcode_e                seq_op    [MAX_SEQ];
reg_idx_t               seq_dest  [MAX_SEQ];
rob_tag_t               seq_tag   [MAX_SEQ];
logic [`DATA_WIDTH-1:0] seq_value [MAX_SEQ];
bit                     seq_done  [MAX_SEQ];

int       n_disp;        // Accepted micro-ops so far
int       used;          // Slots taken, counting a dispatch still on its way in
int       main_commits;
int       sb_commits;    // Commits checked by the scoreboard
int       prev_count;    // Lanes dispatched at the previous falling edge
int       prev_first;
bit       exp_ovf;
rob_tag_t next_tag;
int       pending_seq [$];   // Results the execution units still owe

rob_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .dispatch    (dispatch),
    .count       (count),
    .uops        (uops),
    .alloc       (alloc),
    .alloc_count (alloc_count),
    .alloc_tags  (alloc_tags),
    .space       (space),
    .overflow    (overflow),
    .completes   (completes),
    .commits     (commits),
    .reg_raddr   (reg_raddr),
    .reg_rdata   (reg_rdata)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "Run stopped at the first error");
endtask

task automatic check_commit(input string name, input commit_t got, input commit_t exp);
    if (got !== exp)
        fail_run($sformatf("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
endtask

task automatic check_tags(input string name, input rob_tag_t got, input rob_tag_t exp);
    if (got !== exp)
        fail_run($sformatf("Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
endtask

task automatic check_reg(input string name, input logic [`DATA_WIDTH-1:0] got,
                         input logic [`DATA_WIDTH-1:0] exp);
    if (got !== exp)
        fail_run($sformatf("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
endtask

task automatic check_count(input string name, input rob_count_t got, input rob_count_t exp);
    if (got !== exp)
        fail_run($sformatf("Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
        fail_run($sformatf("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp));
endtask

// Expected record for the s-th accepted micro-op
function automatic commit_t expected_commit(input int s);
    commit_t c;
    c.valid  = 1'b1;
    c.op     = seq_op[s];
    c.dest   = seq_dest[s];
    c.wr_reg = (seq_op[s] == ALU) || (seq_op[s] == LOAD);
    c.value  = c.wr_reg ? seq_value[s] : '0;   // Result-less ops carry zero
    return c;
endfunction

// Last value written to register r by the first upto micro-ops
function automatic logic [`DATA_WIDTH-1:0] expected_reg(input reg_idx_t r, input int upto);
    for (int s = upto - 1; s >= 0; s--) begin
        if ((seq_op[s] == ALU || seq_op[s] == LOAD) && seq_dest[s] == r)
            return seq_value[s];
    end
    return '0;
endfunction

function automatic opcode_e random_op(input bit result_only);
    int r;
    r = int'($urandom % 8);
    if (result_only)
        return (r < 4) ? ALU : LOAD;
    case (r)
        6:       return STORE;
        7:       return NOP;
        4, 5:    return LOAD;
        default: return ALU;
    endcase
endfunction

// One clock of stimulus that accounts commits, checks alloc, completes results and dispatches
task automatic step(input int want, input bit result_only, input bit complete_on);
    int                     idx;
    int                     s;
    logic [`DATA_WIDTH-1:0] val;
    @(negedge clk);
    for (int i = 0; i < `SS_WIDTH; i++) begin
        if (commits[i].valid) begin
            used--;
            main_commits++;
        end
    end
    check_count("space", space, rob_count_t'(`ROB_DEPTH - used));
    check_flag("overflow", overflow, exp_ovf);
    check_flag("alloc", alloc, prev_count > 0);
    if (prev_count > 0)
        check_count("alloc_count", rob_count_t'(alloc_count), rob_count_t'(prev_count));

    // Tags seen this cycle only go live at the next edge, so they join the list after this
    completes = '0;
    for (int i = 0; i < `SS_WIDTH; i++) begin
        if (complete_on && pending_seq.size() > 0 && ($urandom % 3) != 0) begin
            idx = int'($urandom % pending_seq.size());
            s   = pending_seq[idx];
            pending_seq.delete(idx);
            val = $urandom;
            seq_value[s] = val;
            seq_done[s]  = 1'b1;
            completes[i].valid = 1'b1;
            completes[i].tag   = seq_tag[s];
            completes[i].value = val;
        end
    end

    for (int i = 0; i < prev_count; i++) begin
        check_tags($sformatf("alloc_tags[%0d]", i), alloc_tags[i], next_tag);
        seq_tag[prev_first + i] = next_tag;
        next_tag = next_tag + rob_tag_t'(1);
        if (seq_op[prev_first + i] == ALU || seq_op[prev_first + i] == LOAD)
            pending_seq.push_back(prev_first + i);
    end

    dispatch   = 1'b0;
    count      = '0;
    prev_count = 0;
    if (want > 0) begin
        for (int i = 0; i < `SS_WIDTH; i++) begin
            uops[i].op   = random_op(result_only);
            uops[i].dest = reg_idx_t'($urandom);
        end
        dispatch = 1'b1;
        count    = `SS_COUNT_BITS'(want);
        if (want > `ROB_DEPTH - used) begin
            exp_ovf = 1'b1;    // Whole dispatch is dropped
        end else begin
            for (int i = 0; i < want; i++) begin
                seq_op[n_disp + i]   = uops[i].op;
                seq_dest[n_disp + i] = uops[i].dest;
            end
            prev_first = n_disp;
            prev_count = want;
            n_disp += want;
            used   += want;
        end
    end
endtask

task automatic run_random(input int n);
    int sent;
    int want;
    sent = 0;
    while (sent < n) begin
        want = (($urandom % 4) == 0) ? 0 : 1 + int'($urandom % 2);
        if (want > `ROB_DEPTH - used)
            want = 0;
        step(want, 1'b0, 1'b1);
        if (want > 0)
            sent++;
    end
endtask

task automatic drain();
    while (main_commits < n_disp)
        step(0, 1'b0, 1'b1);
    step(0, 1'b0, 1'b1);
    if (sb_commits != n_disp || pending_seq.size() != 0)
        fail_run("The buffer drained but the commit count does not match the dispatches");
endtask

task automatic check_regs();
    for (int r = 0; r < `ARCH_REGS; r++) begin
        @(negedge clk);
        reg_raddr = reg_idx_t'(r);
        #1;
        check_reg($sformatf("reg_rdata[%0d]", r), reg_rdata, expected_reg(reg_idx_t'(r), n_disp));
    end
endtask

initial begin
    void'($urandom(65));
    rst       = 1'b1;
    dispatch  = 1'b0;
    count     = '0;
    uops      = '0;
    completes = '0;
    reg_raddr = '0;
    n_disp       = 0;
    used         = 0;
    main_commits = 0;
    prev_count   = 0;
    prev_first   = 0;
    exp_ovf      = 1'b0;
    next_tag     = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_count("space", space, rob_count_t'(`ROB_DEPTH));
    check_flag("overflow", overflow, 1'b0);
    check_flag("commits[0].valid", commits[0].valid, 1'b0);
    check_flag("commits[1].valid", commits[1].valid, 1'b0);
    check_regs();    // Nothing dispatched yet so every register is expected zero

    run_random(N_RANDOM);
    drain();
    check_regs();

    // Fill with result ops that never complete, then push one too many
    while (`ROB_DEPTH - used >= 2)
        step(2, 1'b1, 1'b0);
    step(1, 1'b1, 1'b0);
    step(0, 1'b1, 1'b0);
    drain();

    run_random(4);   // Tags must carry on as if the dropped op never existed
    drain();
    check_regs();

    $display("Everything OK");
    $finish;
end

// Scoreboard compares every valid commit lane in dispatch order
initial begin
    sb_commits = 0;
    @(negedge rst);
    forever begin
        @(negedge clk);
        if (commits[1].valid && !commits[0].valid)
            fail_run("Commit lane 1 was valid while lane 0 was not");
        for (int i = 0; i < `SS_WIDTH; i++) begin
            if (commits[i].valid) begin
                if (sb_commits >= n_disp)
                    fail_run("A commit appeared that matches no accepted dispatch");
                if ((seq_op[sb_commits] == ALU || seq_op[sb_commits] == LOAD)
                        && !seq_done[sb_commits])
                    fail_run("An instruction committed before its result was reported");
                check_commit($sformatf("commits[%0d]", i), commits[i], expected_commit(sb_commits));
                sb_commits++;
            end
        end
    end
end

initial begin
    repeat (N_TRANS * 40 + 500) @(posedge clk);
    fail_run("Timeout: the run did not finish within the expected number of cycles");
end

endmodule : rob_tb

/* files.f */
+incdir+include
source/uop_pkg.sv
source/rob_pkg.sv
source/dispatch_stage.sv
source/circular_queue.sv
source/commit_stage.sv
source/rob_top.sv
testbench/rob_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing -f files.f --top-module rob_tb > "$LOG" 2>&1 \
    && ./obj_dir/Vrob_tb >> "$LOG" 2>&1

cat "$LOG"

grep -qx "Everything OK" "$LOG" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
